// ==== compile.f ====
src/trace_pkg.sv
src/trace_cond_decode.sv
src/packet_selector.sv
src/qual_tracker.sv
src/addr_compressor.sv
src/trace_priority_top.sv
testbench/tb_clock.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the trace priority testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_top -o tb_top_sim
out=$(./obj_dir/tb_top_sim)
echo "$out"
echo "$out" | grep -q "=== PASS ==="

// ==== src/addr_compressor.sv ====
// address compressor
// counts leading sign bits and gives how many low bits must be kept
`default_nettype none

module addr_compressor #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]        addr_i,
    output logic [$clog2(XLEN):0]  keep_bits_o
);

    localparam int CNT_W = $clog2(XLEN) + 1;

    // leading run of bits equal to the msb, msb included
    logic [CNT_W-1:0] lead_cnt;
    logic             in_run;

    always_comb begin
        // msb always counts
        lead_cnt = CNT_W'(1);
        in_run   = 1'b1;
        for (int i = XLEN - 2; i >= 0; i--) begin
            if (in_run && (addr_i[i] == addr_i[XLEN-1])) begin
                lead_cnt = lead_cnt + CNT_W'(1);
            end else begin
                // first differing bit ends the run
                in_run = 1'b0;
            end
        end
    end

    // one copy of the sign bit stays so the receiver can sign extend
    // all bits equal leaves just that one bit
    assign keep_bits_o = CNT_W'(XLEN) - lead_cnt + CNT_W'(1);

    always_comb begin : check_keep
        // never zero, never more than the address
        assert ((keep_bits_o >= CNT_W'(1)) && (keep_bits_o <= CNT_W'(XLEN)))
            else $error("keep_bits out of range");
    end

endmodule

`default_nettype wire

// ==== src/packet_selector.sv ====
// packet selector
// fixed priority tree choosing the trace packet and the flag commands
`default_nettype none

module packet_selector (
    input  logic                   valid_i,
    input  logic                   tc_qualified_i,
    input  logic                   tc_first_qualified_i,
    input  logic                   tc_gt_max_resync_i,
    input  logic                   lc_exception_i,
    input  logic                   lc_updiscon_i,
    input  logic                   nc_qualified_i,
    input  trace_pkg::cond_flags_t flags_i,
    input  logic                   ended_ntr_q_i,
    input  logic                   ended_rep_q_i,
    input  logic                   reported_q_i,
    output trace_pkg::packet_req_t packet_o,
    output trace_pkg::state_cmd_t  cmd_o,
    output logic                   support_o
);

    // diff_delta with branches to report, addr_only without
    trace_pkg::trace_format_e branch_fmt;

    assign branch_fmt = flags_i.tc_branch_map_empty ? trace_pkg::f_addr_only
                                                    : trace_pkg::f_diff_delta;

    // strobe for the status encoder
    assign support_o = packet_o.valid
                    && (packet_o.format == trace_pkg::f_sync)
                    && (packet_o.subformat == trace_pkg::sf_support);

    always_comb begin : select_packet
        // idle defaults, opt_ext only as inactive value
        packet_o.valid            = 1'b0;
        packet_o.format           = trace_pkg::f_opt_ext;
        packet_o.subformat        = trace_pkg::sf_start;
        packet_o.thaddr           = 1'b0;
        packet_o.lc_tc_mux        = 1'b0;
        packet_o.resync_timer_rst = 1'b0;
        cmd_o.ended_ntr           = 1'b0;
        cmd_o.ended_rep           = 1'b0;
        cmd_o.reported_load       = 1'b0;
        cmd_o.reported_value      = 1'b0;

        if (valid_i) begin
            if (flags_i.tc_support_req) begin
                // encoder state change or lost packets
                packet_o.valid     = 1'b1;
                packet_o.format    = trace_pkg::f_sync;
                packet_o.subformat = trace_pkg::sf_support;
            end else if (tc_qualified_i) begin
                if (lc_exception_i) begin
                    packet_o.valid            = 1'b1;
                    packet_o.format           = trace_pkg::f_sync;
                    packet_o.resync_timer_rst = 1'b1;
                    if (flags_i.tc_exc_only) begin
                        // trap with lc cause, handler address follows later
                        packet_o.subformat   = trace_pkg::sf_trap;
                        cmd_o.reported_load  = 1'b1;
                        cmd_o.reported_value = 1'b1;
                    end else if (reported_q_i) begin
                        // trap already out, resume with a start
                        packet_o.subformat   = trace_pkg::sf_start;
                        cmd_o.reported_load  = 1'b1;
                        cmd_o.reported_value = 1'b0;
                    end else begin
                        // trap and handler address in one packet
                        packet_o.subformat = trace_pkg::sf_trap;
                        packet_o.thaddr    = 1'b1;
                    end
                end else if (tc_first_qualified_i || flags_i.tc_ppccd
                             || tc_gt_max_resync_i) begin
                    packet_o.valid            = 1'b1;
                    packet_o.format           = trace_pkg::f_sync;
                    packet_o.subformat        = trace_pkg::sf_start;
                    packet_o.resync_timer_rst = 1'b1;
                    if (!flags_i.tc_exc_only) begin
                        cmd_o.reported_load  = 1'b1;
                        cmd_o.reported_value = 1'b0;
                    end
                end else if (lc_updiscon_i) begin
                    // uninferable jump last cycle
                    cmd_o.ended_ntr = 1'b1;
                    packet_o.valid  = 1'b1;
                    if (flags_i.tc_exc_only) begin
                        // tc cause via mux
                        packet_o.format           = trace_pkg::f_sync;
                        packet_o.subformat        = trace_pkg::sf_trap;
                        packet_o.lc_tc_mux        = 1'b1;
                        packet_o.resync_timer_rst = 1'b1;
                        cmd_o.reported_load       = 1'b1;
                        cmd_o.reported_value      = 1'b0;
                    end else begin
                        packet_o.format = branch_fmt;
                    end
                end else if (flags_i.tc_resync_br || flags_i.tc_er_n) begin
                    packet_o.valid  = 1'b1;
                    packet_o.format = branch_fmt;
                end else if (flags_i.nc_exc_only || flags_i.nc_ppccd_br
                             || !nc_qualified_i) begin
                    // last qualified instruction gets reported
                    cmd_o.ended_rep = !nc_qualified_i;
                    packet_o.valid  = 1'b1;
                    packet_o.format = branch_fmt;
                end else if (flags_i.tc_rpt_br) begin
                    // full branch map
                    packet_o.valid  = 1'b1;
                    packet_o.format = trace_pkg::f_diff_delta;
                end
            end
        end
    end

    always_comb begin : check_outputs
        // resync reset only travels with a real packet
        assert (!(packet_o.resync_timer_rst && !valid_i))
            else $error("resync_timer_rst set without valid");
        // tracker flags come from exclusive selector branches
        assert (!(ended_ntr_q_i && ended_rep_q_i))
            else $error("both ended flags seen by the selector");
    end

endmodule

`default_nettype wire

// ==== src/qual_tracker.sv ====
// qualification tracker
// holds the ended and reported flags and encodes the support packet status
`default_nettype none

module qual_tracker (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  trace_pkg::state_cmd_t   cmd_i,
    input  logic                    support_i,
    input  logic                    tc_packets_lost_i,
    output logic                    ended_ntr_q_o,
    output logic                    ended_rep_q_o,
    output logic                    reported_q_o,
    output trace_pkg::qual_status_e qual_status_o
);

    // ended flags live for one cycle, reported only moves on a load
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ended_ntr_q_o <= 1'b0;
            ended_rep_q_o <= 1'b0;
            reported_q_o  <= 1'b0;
        end else begin
            ended_ntr_q_o <= cmd_i.ended_ntr;
            ended_rep_q_o <= cmd_i.ended_rep;
            if (cmd_i.reported_load) begin
                reported_q_o <= cmd_i.reported_value;
            end
        end
    end

    // status only has meaning inside a support packet
    always_comb begin
        qual_status_o = trace_pkg::qs_no_change;
        if (support_i) begin
            if (ended_ntr_q_o) begin
                qual_status_o = trace_pkg::qs_ended_ntr;
            end else if (ended_rep_q_o) begin
                qual_status_o = trace_pkg::qs_ended_rep;
            end else if (tc_packets_lost_i) begin
                qual_status_o = trace_pkg::qs_trace_lost;
            end
        end
    end

    // selector never asks for both ends in one cycle
    ended_flags_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(ended_ntr_q_o && ended_rep_q_o)
    ) else $error("ended_ntr and ended_rep both set");

endmodule

`default_nettype wire

// ==== src/trace_cond_decode.sv ====
// trace condition decoder
// folds the raw lc/tc/nc inputs into the conditions used by the priority tree
`default_nettype none

module trace_cond_decode (
    input  trace_pkg::lc_cond_t    lc_i,
    input  trace_pkg::tc_cond_t    tc_i,
    input  trace_pkg::nc_cond_t    nc_i,
    output trace_pkg::cond_flags_t flags_o
);

    // exception without a retired instruction
    assign flags_o.tc_exc_only = tc_i.exception && !tc_i.retired;
    assign flags_o.nc_exc_only = nc_i.exception && !nc_i.retired;

    // precise discontinuity, only privilege change without context support
    assign flags_o.tc_ppccd = tc_i.privchange;

    // resync one step away, worth a packet only with branches pending
    assign flags_o.tc_resync_br = tc_i.et_max_resync && !tc_i.branch_map_empty;

    // exception that still retired an instruction
    assign flags_o.tc_er_n = tc_i.exception && tc_i.retired;

    // branch map must be flushed
    assign flags_o.tc_rpt_br = tc_i.branch_map_full;

    // privilege change next cycle with branches still to report
    assign flags_o.nc_ppccd_br = nc_i.privchange && !nc_i.branch_map_empty;

    // any of these asks for a sync support packet
    assign flags_o.tc_support_req = tc_i.enc_enabled
                                 || tc_i.enc_disabled
                                 || tc_i.opmode_change
                                 || lc_i.final_qualified
                                 || tc_i.packets_lost;

    // branch choice between diff_delta and addr_only
    assign flags_o.tc_branch_map_empty = tc_i.branch_map_empty;

endmodule

`default_nettype wire

// ==== src/trace_pkg.sv ====
// trace priority package
// packet formats, qualification status and the condition and request structs
`default_nettype none

package trace_pkg;

    // packet format, 2 bit field of the encoder header
    typedef enum logic [1:0] {
        f_opt_ext    = 2'b00,
        f_diff_delta = 2'b01,
        f_addr_only  = 2'b10,
        f_sync       = 2'b11
    } trace_format_e;

    // sync subformat
    // context is part of the encoding but never emitted here
    typedef enum logic [1:0] {
        sf_start   = 2'b00,
        sf_trap    = 2'b01,
        sf_context = 2'b10,
        sf_support = 2'b11
    } sync_subformat_e;

    // qualification status carried by support packets
    typedef enum logic [1:0] {
        qs_no_change  = 2'b00,
        qs_ended_rep  = 2'b01,
        qs_trace_lost = 2'b10,
        qs_ended_ntr  = 2'b11
    } qual_status_e;

    // last cycle retirement conditions
    typedef struct packed {
        logic exception;
        logic updiscon;
        logic final_qualified;
    } lc_cond_t;

    // this cycle retirement conditions
    typedef struct packed {
        logic qualified;
        logic exception;
        logic retired;
        logic first_qualified;
        logic privchange;
        // resync counter past / one step before its limit
        logic gt_max_resync;
        logic et_max_resync;
        logic branch_map_empty;
        logic branch_map_full;
        logic enc_enabled;
        logic enc_disabled;
        logic opmode_change;
        logic packets_lost;
        // tied to zero by the driver
        logic spare;
    } tc_cond_t;

    // next cycle retirement conditions
    typedef struct packed {
        logic exception;
        logic privchange;
        logic branch_map_empty;
        logic qualified;
        logic retired;
    } nc_cond_t;

    // combined conditions feeding the priority tree
    typedef struct packed {
        logic tc_exc_only;
        logic tc_ppccd;
        logic tc_resync_br;
        logic tc_er_n;
        logic tc_rpt_br;
        logic nc_exc_only;
        logic nc_ppccd_br;
        logic tc_support_req;
        logic tc_branch_map_empty;
    } cond_flags_t;

    // selected packet and its side outputs
    typedef struct packed {
        logic            valid;
        trace_format_e   format;
        sync_subformat_e subformat;
        logic            thaddr;
        // 0 picks last cycle cause/tval, 1 picks this cycle
        logic            lc_tc_mux;
        logic            resync_timer_rst;
    } packet_req_t;

    // commands for the registered flags
    typedef struct packed {
        logic ended_ntr;
        logic ended_rep;
        logic reported_load;
        logic reported_value;
    } state_cmd_t;

endpackage

`default_nettype wire

// ==== src/trace_priority_top.sv ====
// trace packet priority stage
// decoder, priority tree, flag tracker and address compressor
`default_nettype none

module trace_priority_top #(
    parameter int XLEN = 32
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    valid_i,
    input  trace_pkg::lc_cond_t     lc_i,
    input  trace_pkg::tc_cond_t     tc_i,
    input  trace_pkg::nc_cond_t     nc_i,
    input  logic [XLEN-1:0]         addr_i,
    output trace_pkg::packet_req_t  packet_o,
    output trace_pkg::qual_status_e qual_status_o,
    output logic [$clog2(XLEN):0]   keep_bits_o
);

    trace_pkg::cond_flags_t flags;
    trace_pkg::state_cmd_t  cmd;
    logic                   support;
    // registered flags back to the tree
    logic                   ended_ntr_q;
    logic                   ended_rep_q;
    logic                   reported_q;

    trace_cond_decode i_cond_decode (
        .lc_i    (lc_i),
        .tc_i    (tc_i),
        .nc_i    (nc_i),
        .flags_o (flags)
    );

    packet_selector i_packet_selector (
        .valid_i              (valid_i),
        .tc_qualified_i       (tc_i.qualified),
        .tc_first_qualified_i (tc_i.first_qualified),
        .tc_gt_max_resync_i   (tc_i.gt_max_resync),
        .lc_exception_i       (lc_i.exception),
        .lc_updiscon_i        (lc_i.updiscon),
        .nc_qualified_i       (nc_i.qualified),
        .flags_i              (flags),
        .ended_ntr_q_i        (ended_ntr_q),
        .ended_rep_q_i        (ended_rep_q),
        .reported_q_i         (reported_q),
        .packet_o             (packet_o),
        .cmd_o                (cmd),
        .support_o            (support)
    );

    qual_tracker i_qual_tracker (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .cmd_i             (cmd),
        .support_i         (support),
        .tc_packets_lost_i (tc_i.packets_lost),
        .ended_ntr_q_o     (ended_ntr_q),
        .ended_rep_q_o     (ended_rep_q),
        .reported_q_o      (reported_q),
        .qual_status_o     (qual_status_o)
    );

    // runs alongside, no link to the tree
    addr_compressor #(
        .XLEN (XLEN)
    ) i_addr_compressor (
        .addr_i      (addr_i),
        .keep_bits_o (keep_bits_o)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_checker.sv ====
// output checker for the trace priority stage
// compares sampled dut outputs with expected row values and keeps counts
`default_nettype none

module tb_checker #(
    parameter int KEEP_W = 6
) (
    input trace_pkg::packet_req_t  packet_i,
    input trace_pkg::qual_status_e qual_status_i,
    input logic [KEEP_W-1:0]       keep_bits_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int pass_cnt = 0;
    int fail_cnt = 0;

    // called just before the next edge, outputs settled by then
    task automatic check_row(
        input string                   name,
        input trace_pkg::packet_req_t  exp_pkt,
        input trace_pkg::qual_status_e exp_qual,
        input logic [KEEP_W-1:0]       exp_keep
    );
        string exp_str;
        string act_str;
        if ((packet_i === exp_pkt) && (qual_status_i === exp_qual)
            && (keep_bits_i === exp_keep)) begin
            pass_cnt++;
            $display("ok      %s", name);
        end else begin
            fail_cnt++;
            exp_str = $sformatf("packet %b qual %0d keep %0d", exp_pkt, exp_qual, exp_keep);
            act_str = $sformatf("packet %b qual %0d keep %0d",
                                packet_i, qual_status_i, keep_bits_i);
            $display("FAILED %s: expected %s, actual %s", name, exp_str, act_str);
        end
    endtask

    // closing summary
    task automatic report_totals();
        $display("tests %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
    endtask

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
// testbench clock and reset source
// free running clock, reset held low for a fixed number of cycles
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release away from the edge
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #5 rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_top.sv ====
// trace priority stage testbench
// applies a table of condition rows and checks packet, status and keep bits
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int XLEN          = 32;
    localparam int KEEP_W        = $clog2(XLEN) + 1;
    localparam int RST_CYCLES    = 10;
    localparam int MARGIN_CYCLES = 20;

    // tc bits, msb first as in tc_cond_t
    localparam logic [13:0] T_Q    = 14'h2000;
    localparam logic [13:0] T_EXC  = 14'h1000;
    localparam logic [13:0] T_FQ   = 14'h0400;
    localparam logic [13:0] T_PRIV = 14'h0200;
    localparam logic [13:0] T_GT   = 14'h0100;
    localparam logic [13:0] T_BME  = 14'h0040;
    localparam logic [13:0] T_FULL = 14'h0020;
    localparam logic [13:0] T_EN   = 14'h0010;
    localparam logic [13:0] T_LOST = 14'h0002;
    localparam logic [2:0]  L_EXC  = 3'b100;
    localparam logic [2:0]  L_UPD  = 3'b010;
    localparam logic [4:0]  N_Q    = 5'b00010;

    localparam trace_pkg::qual_status_e Q_NC   = trace_pkg::qs_no_change;
    localparam trace_pkg::qual_status_e Q_REP  = trace_pkg::qs_ended_rep;
    localparam trace_pkg::qual_status_e Q_LOST = trace_pkg::qs_trace_lost;
    localparam trace_pkg::qual_status_e Q_NTR  = trace_pkg::qs_ended_ntr;

    // valid, format, subformat, thaddr, mux, resync reset
    localparam trace_pkg::packet_req_t P_NONE = '0;
    localparam trace_pkg::packet_req_t P_START = '{1'b1, trace_pkg::f_sync,
        trace_pkg::sf_start, 1'b0, 1'b0, 1'b1};
    localparam trace_pkg::packet_req_t P_TRAP = '{1'b1, trace_pkg::f_sync,
        trace_pkg::sf_trap, 1'b0, 1'b0, 1'b1};
    localparam trace_pkg::packet_req_t P_TRAP_TH = '{1'b1, trace_pkg::f_sync,
        trace_pkg::sf_trap, 1'b1, 1'b0, 1'b1};
    localparam trace_pkg::packet_req_t P_TRAP_MUX = '{1'b1, trace_pkg::f_sync,
        trace_pkg::sf_trap, 1'b0, 1'b1, 1'b1};
    localparam trace_pkg::packet_req_t P_SUPPORT = '{1'b1, trace_pkg::f_sync,
        trace_pkg::sf_support, 1'b0, 1'b0, 1'b0};
    localparam trace_pkg::packet_req_t P_DIFF = '{1'b1, trace_pkg::f_diff_delta,
        trace_pkg::sf_start, 1'b0, 1'b0, 1'b0};
    localparam trace_pkg::packet_req_t P_ADDR = '{1'b1, trace_pkg::f_addr_only,
        trace_pkg::sf_start, 1'b0, 1'b0, 1'b0};

    typedef struct packed {
        logic                    valid;
        trace_pkg::lc_cond_t     lc;
        trace_pkg::tc_cond_t     tc;
        trace_pkg::nc_cond_t     nc;
        logic [XLEN-1:0]         addr;
        trace_pkg::packet_req_t  exp_pkt;
        trace_pkg::qual_status_e exp_qual;
        logic [KEEP_W-1:0]       exp_keep;
    } row_t;

    logic                    clk;
    logic                    rst_n;
    logic                    valid;
    trace_pkg::lc_cond_t     lc;
    trace_pkg::tc_cond_t     tc;
    trace_pkg::nc_cond_t     nc;
    logic [XLEN-1:0]         addr;
    trace_pkg::packet_req_t  packet;
    trace_pkg::qual_status_e qual_status;
    logic [KEEP_W-1:0]       keep_bits;

    row_t  rows[$];
    string row_names[$];
    int    cycle_cnt = 0;
    int    timeout_limit = RST_CYCLES + MARGIN_CYCLES;

    tb_clock #(.PERIOD_NS(100), .RST_CYCLES(RST_CYCLES)) clk0 (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    trace_priority_top #(.XLEN(XLEN)) dut0 (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .valid_i       (valid),
        .lc_i          (lc),
        .tc_i          (tc),
        .nc_i          (nc),
        .addr_i        (addr),
        .packet_o      (packet),
        .qual_status_o (qual_status),
        .keep_bits_o   (keep_bits)
    );

    tb_checker #(.KEEP_W(KEEP_W)) chk0 (
        .packet_i      (packet),
        .qual_status_i (qual_status),
        .keep_bits_i   (keep_bits)
    );

    task automatic add_row(
        input string                   name,
        input trace_pkg::lc_cond_t     row_lc,
        input trace_pkg::tc_cond_t     row_tc,
        input trace_pkg::nc_cond_t     row_nc,
        input logic [XLEN-1:0]         row_addr,
        input trace_pkg::packet_req_t  exp_pkt,
        input trace_pkg::qual_status_e exp_qual,
        input logic [KEEP_W-1:0]       exp_keep,
        input logic                    row_valid = 1'b1
    );
        rows.push_back('{row_valid, row_lc, row_tc, row_nc, row_addr, exp_pkt, exp_qual,
                         exp_keep});
        row_names.push_back(name);
    endtask

    // one edge per row, stop if the run stalls
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("timeout: rows not finished after %0d cycles", timeout_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        valid = 1'b0;
        lc    = '0;
        tc    = '0;
        nc    = '0;
        addr  = '0;

        // idle and start rows
        add_row("valid_low", '0, T_Q | T_FQ, N_Q, 32'h0000_0000, P_NONE, Q_NC, 6'd1, 1'b0);
        // flags still at their reset values
        add_row("reset_support", '0, T_EN, N_Q, 32'hF000_0000, P_SUPPORT, Q_NC, 6'd29);
        add_row("reset_trap_thaddr", L_EXC, T_Q, N_Q, 32'h0000_0003, P_TRAP_TH, Q_NC, 6'd3);
        add_row("unqualified", '0, '0, N_Q, 32'hFFFF_FFFF, P_NONE, Q_NC, 6'd1);
        add_row("first_qual", '0, T_Q | T_FQ, N_Q, 32'h8000_0000, P_START, Q_NC, 6'd32);
        add_row("privchange", '0, T_Q | T_PRIV, N_Q, 32'h0000_0062, P_START, Q_NC, 6'd8);
        add_row("resync_timeout", '0, T_Q | T_GT, N_Q, 32'hFFFF_FF80, P_START, Q_NC, 6'd8);
        // trap, then start while reported, then trap with handler address
        add_row("trap_exc_only", L_EXC, T_Q | T_EXC, N_Q, 32'h0000_0001, P_TRAP, Q_NC, 6'd2);
        add_row("start_reported", L_EXC, T_Q, N_Q, 32'h4000_0000, P_START, Q_NC, 6'd32);
        add_row("trap_thaddr", L_EXC, T_Q, N_Q, 32'hFFFF_0000, P_TRAP_TH, Q_NC, 6'd17);
        // updiscon rows, each followed by a support row
        add_row("updiscon_diff", L_UPD, T_Q, N_Q, 32'h0000_FFFF, P_DIFF, Q_NC, 6'd17);
        add_row("support_ntr", '0, T_EN, N_Q, 32'h1234_5678, P_SUPPORT, Q_NTR, 6'd30);
        add_row("updiscon_addr", L_UPD, T_Q | T_BME, N_Q, 32'h7FFF_FFFF, P_ADDR, Q_NC, 6'd32);
        add_row("updiscon_trap", L_UPD, T_Q | T_EXC, N_Q, 32'hC000_0000, P_TRAP_MUX, Q_NC, 6'd31);
        add_row("support_ntr_2", '0, T_EN, N_Q, 32'h0000_0000, P_SUPPORT, Q_NTR, 6'd1);
        // last qualified cycle, then status rows
        add_row("nc_unqualified", '0, T_Q, '0, 32'hFFFF_FFFE, P_DIFF, Q_NC, 6'd2);
        add_row("support_rep", '0, T_EN, N_Q, 32'h0000_0100, P_SUPPORT, Q_REP, 6'd10);
        add_row("support_lost", '0, T_LOST, N_Q, 32'h0000_0000, P_SUPPORT, Q_LOST, 6'd1);
        add_row("map_full", '0, T_Q | T_FULL, N_Q, 32'h0000_0000, P_DIFF, Q_NC, 6'd1);
        add_row("valid_low_end", '0, T_Q | T_EN, N_Q, 32'hFFFF_FFFF, P_NONE, Q_NC, 6'd1, 1'b0);
        timeout_limit = rows.size() + RST_CYCLES + MARGIN_CYCLES;

        @(posedge rst_n);
        foreach (rows[i]) begin
            @(posedge clk);
            #5;
            valid = rows[i].valid;
            lc    = rows[i].lc;
            tc    = rows[i].tc;
            nc    = rows[i].nc;
            addr  = rows[i].addr;
            // sample just ahead of the next edge
            #90;
            chk0.check_row(row_names[i], rows[i].exp_pkt, rows[i].exp_qual, rows[i].exp_keep);
        end

        chk0.report_totals();
        if (chk0.fail_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
